//--- hw/tcdm_cfg.svh
// bank count, bank depth and port widths of the tcdm cluster memory
`ifndef TCDM_CFG_SVH
`define TCDM_CFG_SVH

// number of word-interleaved banks, must stay a power of two
`define TCDM_NB_BANKS 8

// bits of the bank index, log2 of the bank count
`define TCDM_BANK_IW 3

// word address inside one bank, 64 rows
`define TCDM_BANK_AW 6

// narrow core word
`define TCDM_WORD_DW 32

// wide accelerator port
`define TCDM_WIDE_DW 128

// 32-bit lanes carried by one wide word
`define TCDM_NB_LANES 4

`endif

//--- hw/tcdm_pkg.sv
// tcdm types: word, byte enable, wide data, bank index, row and the byte address union
`include "tcdm_cfg.svh"

package tcdm_pkg;

  // one bank word and its byte enables
  typedef logic [`TCDM_WORD_DW-1:0]   tcdm_word_t;
  typedef logic [`TCDM_WORD_DW/8-1:0] tcdm_be_t;

  // wide accelerator payload, one byte enable per byte
  typedef logic [`TCDM_WIDE_DW-1:0]   tcdm_wide_t;
  typedef logic [`TCDM_WIDE_DW/8-1:0] tcdm_wide_be_t;

  // bank number and row inside a bank
  typedef logic [`TCDM_BANK_IW-1:0] bank_idx_t;
  typedef logic [`TCDM_BANK_AW-1:0] row_t;

  // byte address seen either raw or split for word interleaving
  // consecutive words go to consecutive banks, the row sits above the bank index
  typedef union packed {
    logic [31:0] flat;
    struct packed {
      logic [31-`TCDM_BANK_AW-`TCDM_BANK_IW-2:0] unused;
      row_t                                      row;
      bank_idx_t                                 bank;
      logic [1:0]                                byte_off;
    } fields;
  } tcdm_addr_u;

endpackage

//--- hw/tcdm_bank.sv
// single-port sram bank model with byte-enabled writes and a registered read port
`timescale 1ns/1ps
`include "tcdm_cfg.svh"

module tcdm_bank
  import tcdm_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       req_i,
  input  logic       wen_i,
  input  row_t       row_i,
  input  tcdm_word_t data_i,
  input  tcdm_be_t   be_i,
  output tcdm_word_t r_data_o
);

  localparam int unsigned NB_ROWS  = 2 ** `TCDM_BANK_AW;
  localparam int unsigned NB_BYTES = `TCDM_WORD_DW / 8;

  // storage array, contents undefined until written
  tcdm_word_t mem_q [NB_ROWS];

  always_ff @(posedge clk_i) begin
    // wen low is a write, only enabled bytes change
    if (req_i && !wen_i) begin
      for (int b = 0; b < NB_BYTES; b++) begin
        if (be_i[b]) begin
          mem_q[row_i][b*8 +: 8] <= data_i[b*8 +: 8];
        end
      end
    end
    // read data is ready the cycle after the accepting edge
    if (req_i && wen_i) begin
      r_data_o <= mem_q[row_i];
    end
  end

  // a live request must come with a known direction and row
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_i |-> !$isunknown({wen_i, row_i}))
    else $error("tcdm_bank: request with unknown wen or row");

endmodule

//--- hw/narrow_router.sv
// narrow router steering the 32-bit core port to one interleaved bank and back
`timescale 1ns/1ps
`include "tcdm_cfg.svh"

module narrow_router
  import tcdm_pkg::*;
(
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            clear_i,
  input  logic                            req_i,
  input  logic                            wen_i,
  input  tcdm_addr_u                      add_i,
  input  tcdm_word_t                      data_i,
  input  tcdm_be_t                        be_i,
  output logic                            gnt_o,
  output logic                            r_valid_o,
  output tcdm_word_t                      r_data_o,
  output logic [`TCDM_NB_BANKS-1:0]       bank_req_o,
  output logic [`TCDM_NB_BANKS-1:0]       bank_wen_o,
  output row_t [`TCDM_NB_BANKS-1:0]       bank_row_o,
  output tcdm_word_t [`TCDM_NB_BANKS-1:0] bank_data_o,
  output tcdm_be_t [`TCDM_NB_BANKS-1:0]   bank_be_o,
  input  logic [`TCDM_NB_BANKS-1:0]       bank_gnt_i,
  input  tcdm_word_t [`TCDM_NB_BANKS-1:0] bank_r_data_i
);

  bank_idx_t sel_bank;
  bank_idx_t sel_bank_q;
  logic      gnt_q;

  // bank index straight from the interleaving bits
  assign sel_bank = add_i.fields.bank;

  // only the addressed bank sees req while the rest is broadcast
  always_comb begin
    for (int b = 0; b < `TCDM_NB_BANKS; b++) begin
      bank_req_o[b]  = req_i && (sel_bank == bank_idx_t'(b));
      bank_wen_o[b]  = wen_i;
      bank_row_o[b]  = add_i.fields.row;
      bank_data_o[b] = data_i;
      bank_be_o[b]   = be_i;
    end
  end

  // grant mirrors the arbiter decision on the selected bank
  assign gnt_o = req_i & bank_gnt_i[sel_bank];

  // remember which bank answers next cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      gnt_q      <= 1'b0;
      sel_bank_q <= '0;
    end else if (clear_i) begin
      gnt_q <= 1'b0;
    end else begin
      gnt_q <= gnt_o;
      if (gnt_o) begin
        sel_bank_q <= sel_bank;
      end
    end
  end

  // r_valid follows every grant by one cycle for reads and writes alike
  assign r_valid_o = gnt_q;
  assign r_data_o  = bank_r_data_i[sel_bank_q];

  // the arbiter never grants a bank this port did not ask for
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (bank_gnt_i & ~bank_req_o) == '0)
    else $error("narrow_router: grant on a bank that was not requested");

endmodule

//--- hw/wide_router.sv
// wide router splitting the wide port into lanes over adjacent banks with row wrap
`timescale 1ns/1ps
`include "tcdm_cfg.svh"

module wide_router
  import tcdm_pkg::*;
(
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            clear_i,
  input  logic                            req_i,
  input  logic                            wen_i,
  input  tcdm_addr_u                      add_i,
  input  tcdm_wide_t                      data_i,
  input  tcdm_wide_be_t                   be_i,
  output logic                            gnt_o,
  output logic                            r_valid_o,
  output tcdm_wide_t                      r_data_o,
  output logic [`TCDM_NB_BANKS-1:0]       bank_req_o,
  output logic [`TCDM_NB_BANKS-1:0]       bank_wen_o,
  output row_t [`TCDM_NB_BANKS-1:0]       bank_row_o,
  output tcdm_word_t [`TCDM_NB_BANKS-1:0] bank_data_o,
  output tcdm_be_t [`TCDM_NB_BANKS-1:0]   bank_be_o,
  input  logic [`TCDM_NB_BANKS-1:0]       bank_gnt_i,
  input  tcdm_word_t [`TCDM_NB_BANKS-1:0] bank_r_data_i
);

  localparam int unsigned NB_BANKS = `TCDM_NB_BANKS;
  localparam int unsigned NB_LANES = `TCDM_NB_LANES;
  localparam int unsigned WORD_DW  = `TCDM_WORD_DW;
  localparam int unsigned WORD_BW  = `TCDM_WORD_DW / 8;
  // lane select width for a power-of-two lane count
  localparam int unsigned LANE_W   = $clog2(NB_LANES);

  // first bank of the span where lane 0 lands
  bank_idx_t offset;
  row_t      base_row;

  // steering kept for the response cycle
  bank_idx_t offset_q;
  logic      gnt_q;

  assign offset   = add_i.fields.bank;
  assign base_row = add_i.fields.row;

  // per bank the lane that maps onto it, and whether that lane exists
  always_comb begin : lane_to_bank
    bank_idx_t             lane;
    logic [LANE_W-1:0]     lane_sel;
    for (int b = 0; b < NB_BANKS; b++) begin
      // distance from the span start modulo the bank count
      lane     = bank_idx_t'(b) - offset;
      lane_sel = lane[LANE_W-1:0];

      bank_req_o[b] = req_i && (lane < bank_idx_t'(NB_LANES));
      bank_wen_o[b] = wen_i;

      // banks below the span start are only reached by wrapping,
      // they hold the next row of the wide word
      if (bank_idx_t'(b) < offset) begin
        bank_row_o[b] = base_row + row_t'(1);
      end else begin
        bank_row_o[b] = base_row;
      end

      // rotate lane payload into bank order
      // untargeted banks see junk lanes with req low
      bank_data_o[b] = data_i[lane_sel*WORD_DW +: WORD_DW];
      bank_be_o[b]   = be_i[lane_sel*WORD_BW +: WORD_BW];
    end
  end

  // all lanes go together or not at all
  assign gnt_o = req_i && ((bank_gnt_i & bank_req_o) == bank_req_o);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      gnt_q    <= 1'b0;
      offset_q <= '0;
    end else if (clear_i) begin
      gnt_q <= 1'b0;
    end else begin
      gnt_q <= gnt_o;
      // hold the rotation until the next accepted request
      if (gnt_o) begin
        offset_q <= offset;
      end
    end
  end

  assign r_valid_o = gnt_q;

  // lane l of the response comes from bank offset + l, wrapping around
  always_comb begin : bank_to_lane
    bank_idx_t src;
    for (int l = 0; l < NB_LANES; l++) begin
      src = offset_q + bank_idx_t'(l);
      r_data_o[l*WORD_DW +: WORD_DW] = bank_r_data_i[src];
    end
  end

  // the arbiter grants every requested lane or none of them
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (bank_gnt_i == '0) || (bank_gnt_i == bank_req_o))
    else $error("wide_router: partial or stray lane grant from the arbiter");

endmodule

//--- hw/bank_conflict_arbiter.sv
// bank conflict arbiter merging narrow and wide per-bank requests with narrow priority
`timescale 1ns/1ps
`include "tcdm_cfg.svh"

module bank_conflict_arbiter
  import tcdm_pkg::*;
(
  // narrow router side
  input  logic [`TCDM_NB_BANKS-1:0]       narrow_req_i,
  input  logic [`TCDM_NB_BANKS-1:0]       narrow_wen_i,
  input  row_t [`TCDM_NB_BANKS-1:0]       narrow_row_i,
  input  tcdm_word_t [`TCDM_NB_BANKS-1:0] narrow_data_i,
  input  tcdm_be_t [`TCDM_NB_BANKS-1:0]   narrow_be_i,
  // wide router side
  input  logic [`TCDM_NB_BANKS-1:0]       wide_req_i,
  input  logic [`TCDM_NB_BANKS-1:0]       wide_wen_i,
  input  row_t [`TCDM_NB_BANKS-1:0]       wide_row_i,
  input  tcdm_word_t [`TCDM_NB_BANKS-1:0] wide_data_i,
  input  tcdm_be_t [`TCDM_NB_BANKS-1:0]   wide_be_i,
  // grants back to each router
  output logic [`TCDM_NB_BANKS-1:0]       narrow_gnt_o,
  output logic [`TCDM_NB_BANKS-1:0]       wide_gnt_o,
  // bank side
  output logic [`TCDM_NB_BANKS-1:0]       bank_req_o,
  output logic [`TCDM_NB_BANKS-1:0]       bank_wen_o,
  output row_t [`TCDM_NB_BANKS-1:0]       bank_row_o,
  output tcdm_word_t [`TCDM_NB_BANKS-1:0] bank_data_o,
  output tcdm_be_t [`TCDM_NB_BANKS-1:0]   bank_be_o
);

  // banks wanted by both initiators in this cycle
  logic [`TCDM_NB_BANKS-1:0] overlap;
  logic                      wide_ok;

  assign overlap = narrow_req_i & wide_req_i;

  // wide port only moves when none of its banks is taken
  assign wide_ok = ~|overlap;

  // narrow always wins so a single bank never stalls the core
  assign narrow_gnt_o = narrow_req_i;

  // wide grant is all or nothing over its lanes
  assign wide_gnt_o = wide_ok ? wide_req_i : '0;

  // per-bank mux of the winner's fields
  always_comb begin
    for (int b = 0; b < `TCDM_NB_BANKS; b++) begin
      bank_req_o[b] = narrow_gnt_o[b] | wide_gnt_o[b];
      if (narrow_req_i[b]) begin
        bank_wen_o[b]  = narrow_wen_i[b];
        bank_row_o[b]  = narrow_row_i[b];
        bank_data_o[b] = narrow_data_i[b];
        bank_be_o[b]   = narrow_be_i[b];
      end else begin
        // idle banks also see wide fields while req stays low there
        bank_wen_o[b]  = wide_wen_i[b];
        bank_row_o[b]  = wide_row_i[b];
        bank_data_o[b] = wide_data_i[b];
        bank_be_o[b]   = wide_be_i[b];
      end
    end
  end

  // the core port reaches a single bank per cycle
  always_comb begin
    assert final ($onehot0(narrow_req_i))
      else $error("bank_conflict_arbiter: narrow request on more than one bank");
  end

endmodule

//--- hw/tcdm_subsys.sv
// tcdm subsystem top: narrow and wide routers, bank arbiter and the bank array
`timescale 1ns/1ps
`include "tcdm_cfg.svh"

module tcdm_subsys
  import tcdm_pkg::*;
(
  input  logic          clk_i,
  input  logic          rst_ni,
  input  logic          clear_i,
  // core port
  input  logic          narrow_req_i,
  input  logic          narrow_wen_i,
  input  tcdm_addr_u    narrow_add_i,
  input  tcdm_word_t    narrow_data_i,
  input  tcdm_be_t      narrow_be_i,
  output logic          narrow_gnt_o,
  output logic          narrow_r_valid_o,
  output tcdm_word_t    narrow_r_data_o,
  // accelerator port
  input  logic          wide_req_i,
  input  logic          wide_wen_i,
  input  tcdm_addr_u    wide_add_i,
  input  tcdm_wide_t    wide_data_i,
  input  tcdm_wide_be_t wide_be_i,
  output logic          wide_gnt_o,
  output logic          wide_r_valid_o,
  output tcdm_wide_t    wide_r_data_o
);

  localparam int unsigned NB = `TCDM_NB_BANKS;

  // narrow router to arbiter
  logic [NB-1:0]       n_req;
  logic [NB-1:0]       n_wen;
  row_t [NB-1:0]       n_row;
  tcdm_word_t [NB-1:0] n_data;
  tcdm_be_t [NB-1:0]   n_be;
  logic [NB-1:0]       n_gnt;

  // wide router to arbiter
  logic [NB-1:0]       w_req;
  logic [NB-1:0]       w_wen;
  row_t [NB-1:0]       w_row;
  tcdm_word_t [NB-1:0] w_data;
  tcdm_be_t [NB-1:0]   w_be;
  logic [NB-1:0]       w_gnt;

  // arbiter to banks, read data broadcast to both routers
  logic [NB-1:0]       b_req;
  logic [NB-1:0]       b_wen;
  row_t [NB-1:0]       b_row;
  tcdm_word_t [NB-1:0] b_data;
  tcdm_be_t [NB-1:0]   b_be;
  tcdm_word_t [NB-1:0] b_r_data;

  narrow_router i_narrow_router (
    .clk_i, .rst_ni, .clear_i,
    .req_i (narrow_req_i), .wen_i (narrow_wen_i), .add_i (narrow_add_i),
    .data_i (narrow_data_i), .be_i (narrow_be_i),
    .gnt_o (narrow_gnt_o), .r_valid_o (narrow_r_valid_o), .r_data_o (narrow_r_data_o),
    .bank_req_o (n_req), .bank_wen_o (n_wen), .bank_row_o (n_row),
    .bank_data_o (n_data), .bank_be_o (n_be),
    .bank_gnt_i (n_gnt), .bank_r_data_i (b_r_data)
  );

  wide_router i_wide_router (
    .clk_i, .rst_ni, .clear_i,
    .req_i (wide_req_i), .wen_i (wide_wen_i), .add_i (wide_add_i),
    .data_i (wide_data_i), .be_i (wide_be_i),
    .gnt_o (wide_gnt_o), .r_valid_o (wide_r_valid_o), .r_data_o (wide_r_data_o),
    .bank_req_o (w_req), .bank_wen_o (w_wen), .bank_row_o (w_row),
    .bank_data_o (w_data), .bank_be_o (w_be),
    .bank_gnt_i (w_gnt), .bank_r_data_i (b_r_data)
  );

  bank_conflict_arbiter i_arbiter (
    .narrow_req_i (n_req), .narrow_wen_i (n_wen), .narrow_row_i (n_row),
    .narrow_data_i (n_data), .narrow_be_i (n_be),
    .wide_req_i (w_req), .wide_wen_i (w_wen), .wide_row_i (w_row),
    .wide_data_i (w_data), .wide_be_i (w_be),
    .narrow_gnt_o (n_gnt), .wide_gnt_o (w_gnt),
    .bank_req_o (b_req), .bank_wen_o (b_wen), .bank_row_o (b_row),
    .bank_data_o (b_data), .bank_be_o (b_be)
  );

  // word-interleaved bank array
  for (genvar b = 0; b < NB; b++) begin : gen_bank
    tcdm_bank i_bank (
      .clk_i, .rst_ni,
      .req_i (b_req[b]), .wen_i (b_wen[b]), .row_i (b_row[b]),
      .data_i (b_data[b]), .be_i (b_be[b]), .r_data_o (b_r_data[b])
    );
  end

endmodule

//--- verif/tcdm_subsys_tb.sv
// directed testbench for tcdm_subsys with reference memory, compare tasks and watchdog
`timescale 1ns/1ps
`include "tcdm_cfg.svh"

module tcdm_subsys_tb
  import tcdm_pkg::*;
();

  localparam int NB       = `TCDM_NB_BANKS;
  localparam int NROWS    = 2 ** `TCDM_BANK_AW;
  localparam int NLANES   = `TCDM_NB_LANES;
  localparam int RST_CYC  = 4;
  localparam int MAX_WAIT = 16;
  // access counts per phase, each access takes at most three cycles
  localparam int FILL_OPS = 2 * NROWS;
  localparam int DIR_OPS  = 80;
  localparam int RAND_OPS = 40;
  localparam int TEST_CYCLES = RST_CYC + 3 * (FILL_OPS + DIR_OPS + RAND_OPS);

  logic clk_i, rst_ni, clear_i;
  logic narrow_req_i, narrow_wen_i, narrow_gnt_o, narrow_r_valid_o;
  tcdm_addr_u narrow_add_i;
  tcdm_word_t narrow_data_i, narrow_r_data_o;
  tcdm_be_t narrow_be_i;
  logic wide_req_i, wide_wen_i, wide_gnt_o, wide_r_valid_o;
  tcdm_addr_u wide_add_i;
  tcdm_wide_t wide_data_i, wide_r_data_o;
  tcdm_wide_be_t wide_be_i;

  // reference memory, indexed by bank then row
  tcdm_word_t ref_mem [NB][NROWS];
  logic [31:0] lcg_state;
  int value_errs;
  int other_errs;

  tcdm_subsys DUT (.*);

  initial clk_i = 1'b0;
  always #10 clk_i = ~clk_i;

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic tcdm_wide_t rand_wide();
    return {next_rand(), next_rand(), next_rand(), next_rand()};
  endfunction

  function automatic tcdm_addr_u make_addr(int bank, int row);
    tcdm_addr_u a;
    a.flat = '0;
    a.fields.row = row_t'(row);
    a.fields.bank = bank_idx_t'(bank);
    return a;
  endfunction

  // lane l of a wide word starting at bank b sits in bank b+l, next row once it wraps
  function automatic int lane_bank(int bank, int lane);
    return (bank + lane) % NB;
  endfunction

  function automatic int lane_row(int bank, int row, int lane);
    return (bank + lane >= NB) ? (row + 1) % NROWS : row;
  endfunction

  function automatic tcdm_word_t merge_bytes(tcdm_word_t old_w, tcdm_word_t new_w, tcdm_be_t be);
    tcdm_word_t res;
    res = old_w;
    for (int i = 0; i < 4; i++) begin
      if (be[i]) begin
        res[i*8 +: 8] = new_w[i*8 +: 8];
      end
    end
    return res;
  endfunction

  function automatic tcdm_wide_t ref_wide(int bank, int row);
    tcdm_wide_t w;
    for (int l = 0; l < NLANES; l++) begin
      w[l*32 +: 32] = ref_mem[lane_bank(bank, l)][lane_row(bank, row, l)];
    end
    return w;
  endfunction

  task automatic check_word(string name, tcdm_word_t exp, tcdm_word_t act);
    if (act !== exp) begin
      value_errs++;
      $display("[FAIL] %s expected %h got %h at %0t", name, exp, act, $time);
    end
  endtask

  task automatic check_wide(string name, tcdm_wide_t exp, tcdm_wide_t act);
    if (act !== exp) begin
      value_errs++;
      $display("[FAIL] %s expected %h got %h at %0t", name, exp, act, $time);
    end
  endtask

  task automatic check_bit(string name, logic exp, logic act);
    if (act !== exp) begin
      value_errs++;
      $display("[FAIL] %s expected %h got %h at %0t", name, exp, act, $time);
    end
  endtask

  // one narrow access, entered and left at a falling edge
  task automatic narrow_access(logic wen, int bank, int row, tcdm_word_t data, tcdm_be_t be);
    int waits;
    tcdm_word_t exp;
    waits = 0;
    narrow_req_i  = 1'b1;
    narrow_wen_i  = wen;
    narrow_add_i  = make_addr(bank, row);
    narrow_data_i = data;
    narrow_be_i   = be;
    #2;
    while (!narrow_gnt_o && waits < MAX_WAIT) begin
      @(negedge clk_i);
      #2;
      waits++;
    end
    if (!narrow_gnt_o) begin
      other_errs++;
      $display("narrow request to bank %0d row %0d was never granted", bank, row);
      narrow_req_i = 1'b0;
      @(negedge clk_i);
      return;
    end
    // accepting edge, writes land in the model here
    @(posedge clk_i);
    if (!wen) begin
      ref_mem[bank][row] = merge_bytes(ref_mem[bank][row], data, be);
    end
    exp = ref_mem[bank][row];
    @(negedge clk_i);
    narrow_req_i = 1'b0;
    check_bit("narrow_r_valid_o", 1'b1, narrow_r_valid_o);
    if (wen) begin
      check_word("narrow_r_data_o", exp, narrow_r_data_o);
    end
    // response lasts a single cycle
    @(negedge clk_i);
    check_bit("narrow_r_valid_o", 1'b0, narrow_r_valid_o);
  endtask

  task automatic wide_access(logic wen, int bank, int row, tcdm_wide_t data, tcdm_wide_be_t be);
    int waits;
    int b;
    int r;
    tcdm_wide_t exp;
    waits = 0;
    wide_req_i  = 1'b1;
    wide_wen_i  = wen;
    wide_add_i  = make_addr(bank, row);
    wide_data_i = data;
    wide_be_i   = be;
    #2;
    while (!wide_gnt_o && waits < MAX_WAIT) begin
      @(negedge clk_i);
      #2;
      waits++;
    end
    if (!wide_gnt_o) begin
      other_errs++;
      $display("wide request to bank %0d row %0d was never granted", bank, row);
      wide_req_i = 1'b0;
      @(negedge clk_i);
      return;
    end
    @(posedge clk_i);
    if (!wen) begin
      for (int l = 0; l < NLANES; l++) begin
        b = lane_bank(bank, l);
        r = lane_row(bank, row, l);
        ref_mem[b][r] = merge_bytes(ref_mem[b][r], data[l*32 +: 32], be[l*4 +: 4]);
      end
    end
    exp = ref_wide(bank, row);
    @(negedge clk_i);
    wide_req_i = 1'b0;
    check_bit("wide_r_valid_o", 1'b1, wide_r_valid_o);
    if (wen) begin
      check_wide("wide_r_data_o", exp, wide_r_data_o);
    end
    @(negedge clk_i);
    check_bit("wide_r_valid_o", 1'b0, wide_r_valid_o);
  endtask

  // narrow and wide reads issued together, wide stalls one cycle on overlap
  task automatic bank_conflict(int n_bank, int n_row, int w_bank, int w_row);
    logic overlap;
    tcdm_word_t n_exp;
    tcdm_wide_t w_exp;
    overlap = 1'b0;
    for (int l = 0; l < NLANES; l++) begin
      if (lane_bank(w_bank, l) == n_bank) begin
        overlap = 1'b1;
      end
    end
    n_exp = ref_mem[n_bank][n_row];
    w_exp = ref_wide(w_bank, w_row);
    narrow_req_i = 1'b1;
    narrow_wen_i = 1'b1;
    narrow_add_i = make_addr(n_bank, n_row);
    wide_req_i   = 1'b1;
    wide_wen_i   = 1'b1;
    wide_add_i   = make_addr(w_bank, w_row);
    #2;
    check_bit("narrow_gnt_o", 1'b1, narrow_gnt_o);
    check_bit("wide_gnt_o", !overlap, wide_gnt_o);
    @(negedge clk_i);
    narrow_req_i = 1'b0;
    check_bit("narrow_r_valid_o", 1'b1, narrow_r_valid_o);
    check_word("narrow_r_data_o", n_exp, narrow_r_data_o);
    check_bit("wide_r_valid_o", !overlap, wide_r_valid_o);
    if (overlap) begin
      // narrow dropped, the held wide request goes through now
      #2;
      check_bit("wide_gnt_o", 1'b1, wide_gnt_o);
      @(negedge clk_i);
      check_bit("narrow_r_valid_o", 1'b0, narrow_r_valid_o);
      check_bit("wide_r_valid_o", 1'b1, wide_r_valid_o);
    end
    check_wide("wide_r_data_o", w_exp, wide_r_data_o);
    wide_req_i = 1'b0;
    @(negedge clk_i);
    check_bit("narrow_r_valid_o", 1'b0, narrow_r_valid_o);
    check_bit("wide_r_valid_o", 1'b0, wide_r_valid_o);
  endtask

  task automatic reset_and_narrow();
    tcdm_word_t d;
    check_bit("narrow_r_valid_o", 1'b0, narrow_r_valid_o);
    check_bit("wide_r_valid_o", 1'b0, wide_r_valid_o);
    for (int b = 0; b < NB; b++) begin
      d = next_rand();
      narrow_access(1'b0, b, (b * 7) % NROWS, d, 4'hf);
      narrow_access(1'b1, b, (b * 7) % NROWS, '0, 4'hf);
    end
  endtask

  // full-row wide writes at banks 0 and 4 define every word of the model
  task automatic fill_memory();
    for (int r = 0; r < NROWS; r++) begin
      wide_access(1'b0, 0, r, rand_wide(), '1);
      wide_access(1'b0, 4, r, rand_wide(), '1);
    end
  endtask

  // wide write, wide read back, then each lane seen by the narrow port
  task automatic wide_and_lanes(int bank, int row, tcdm_wide_be_t be);
    wide_access(1'b0, bank, row, rand_wide(), be);
    wide_access(1'b1, bank, row, '0, '1);
    for (int l = 0; l < NLANES; l++) begin
      narrow_access(1'b1, lane_bank(bank, l), lane_row(bank, row, l), '0, 4'hf);
    end
  endtask

  task automatic byte_enables();
    narrow_access(1'b0, 2, 40, next_rand(), 4'b0101);
    narrow_access(1'b1, 2, 40, '0, 4'hf);
    narrow_access(1'b0, 5, 41, next_rand(), 4'b1000);
    narrow_access(1'b1, 5, 41, '0, 4'hf);
    wide_and_lanes(3, 30, 16'h0f3c);
    wide_and_lanes(7, 31, 16'ha5c3);
  endtask

  task automatic random_mix();
    logic [31:0] r;
    for (int i = 0; i < RAND_OPS; i++) begin
      r = next_rand();
      case (r[10:9])
        2'd0: narrow_access(1'b1, r[2:0], r[8:3], '0, 4'hf);
        2'd1: narrow_access(1'b0, r[2:0], r[8:3], next_rand(), r[14:11]);
        2'd2: wide_access(1'b1, r[2:0], r[8:3], '0, '1);
        default: wide_access(1'b0, r[2:0], r[8:3], rand_wide(), r[30:15]);
      endcase
    end
  endtask

  initial begin
    lcg_state     = 32'hb095;
    value_errs    = 0;
    other_errs    = 0;
    rst_ni        = 1'b0;
    clear_i       = 1'b0;
    narrow_req_i  = 1'b0;
    narrow_wen_i  = 1'b1;
    narrow_add_i  = '0;
    narrow_data_i = '0;
    narrow_be_i   = '0;
    wide_req_i    = 1'b0;
    wide_wen_i    = 1'b1;
    wide_add_i    = '0;
    wide_data_i   = '0;
    wide_be_i     = '0;
    repeat (RST_CYC) @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);
    reset_and_narrow();
    fill_memory();
    // aligned spans
    wide_and_lanes(0, 10, '1);
    wide_and_lanes(4, 11, '1);
    // spans that wrap into the next row, the last one also wraps the row
    wide_and_lanes(6, 20, '1);
    wide_and_lanes(5, NROWS - 1, '1);
    byte_enables();
    bank_conflict(2, 12, 0, 12);
    bank_conflict(0, 13, 6, 14);
    bank_conflict(5, 15, 6, 15);
    bank_conflict(7, 16, 0, 17);
    random_mix();
    $display("errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
    if (value_errs + other_errs == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

  // upper bound on run time, derived from the access counts above
  initial begin : watchdog
    #(TEST_CYCLES * 20 + 2000);
    $display("timeout hit, tests did not complete within %0d cycles", TEST_CYCLES);
    $display("TEST FAIL");
    $finish;
  end

endmodule

//--- tcdm_subsys.f
+incdir+hw
hw/tcdm_pkg.sv
hw/tcdm_bank.sv
hw/narrow_router.sv
hw/wide_router.sv
hw/bank_conflict_arbiter.sv
hw/tcdm_subsys.sv
verif/tcdm_subsys_tb.sv
